/* source/icache_pkg.sv */
// Cache address, tag, set index and line data types with the fill and fetch line structs
package icache_pkg;

// ==========================================================================
// Geometry
// ==========================================================================

	// Sets in each bank
	// The index and tag widths below are derived from this count
	localparam int LINES = 16;

	// A fetch address is split as tag [31:9], set [8:5], bank [4], offset [3:0]
	// Bit 4 picks the even or odd bank so one lookup can return two lines

// ==========================================================================
// Plain vector types
// ==========================================================================

	// Byte address as seen by the fetch unit and the snoop bus
	typedef logic [31:0] addr_t;

	// Address of a 16 byte line, which is bits 31 to 4 of a byte address
	typedef logic [31:4] line_addr_t;

	// One cache line of 16 bytes
	typedef logic [127:0] line_data_t;

	// Set within one bank, taken from address bits 8 to 5
	typedef logic [$clog2(LINES)-1:0] set_index_t;

	// Virtual or physical tag, address bits 31 to 9
	typedef logic [31:9] line_tag_t;

	// Identity of a cache on the snoop bus
	typedef logic [3:0] cid_t;

// ==========================================================================
// Structs
// ==========================================================================

	// A whole line written in from outside
	// The virtual line address picks the bank and set and gives the lookup tag
	// The physical tag is kept for snoop matching only
	typedef struct packed {
		line_addr_t vadr;
		line_tag_t  ptag;
		line_data_t data;
	} fill_line_t;

	// One line handed back to the fetch unit
	// v is high when the line was found in its bank
	typedef struct packed {
		logic       v;
		line_addr_t vadr;
		line_data_t data;
	} fetch_line_t;

endpackage

/* source/icache_line_ram.sv */
// Line data RAM for one bank with one write port and one registered read port
module icache_line_ram #(
	parameter int WAYS = 4
) (
	input  logic                                                  clk,
	input  logic                                                  wr_i,
	input  logic [$clog2(WAYS)+$bits(icache_pkg::set_index_t)-1:0] wadr_i,
	input  logic [$clog2(WAYS)+$bits(icache_pkg::set_index_t)-1:0] radr_i,
	input  icache_pkg::line_data_t                                wdata_i,
	output icache_pkg::line_data_t                                rdata_o
);

	import icache_pkg::*;

	// The address is the way number on top of the set index
	// so each way occupies its own block of LINES entries
	line_data_t mem [WAYS*LINES];

	// Write port
	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem[wadr_i] <= wdata_i;
		end
	end

	// Read port is registered
	// A read of the entry written on the same edge returns the old line
	always_ff @(posedge clk) begin
		rdata_o <= mem[radr_i];
	end

endmodule

/* source/icache_tag_store.sv */
// Virtual and physical tag arrays of one bank with a registered lookup read
module icache_tag_store #(
	parameter int WAYS = 4
) (
	input  logic                                    clk,
	// Tag write from a fill
	input  logic                                    wr_i,
	input  logic [$clog2(WAYS)-1:0]                 way_i,
	input  icache_pkg::set_index_t                  ndx_i,
	input  icache_pkg::line_tag_t                   vtag_i,
	input  icache_pkg::line_tag_t                   ptag_i,
	// Lookup read of all ways of one set
	input  icache_pkg::set_index_t                  rndx_i,
	output icache_pkg::line_tag_t [WAYS-1:0]        vtags_o,
	// Snoop read of all physical tags of one set
	input  icache_pkg::set_index_t                  ptag_ndx_i,
	output icache_pkg::line_tag_t [WAYS-1:0]        ptags_o
);

	import icache_pkg::*;

	// One tag per way and set
	line_tag_t vtag_mem [WAYS][LINES];
	line_tag_t ptag_mem [WAYS][LINES];

// ==========================================================================
// Write
// ==========================================================================

	// Both tags of a line are written together when the line is filled
	always_ff @(posedge clk) begin
		if (wr_i) begin
			vtag_mem[way_i][ndx_i] <= vtag_i;
			ptag_mem[way_i][ndx_i] <= ptag_i;
		end
	end

// ==========================================================================
// Read
// ==========================================================================

	// Lookup tags are registered on the edge that takes the lookup strobe
	// A fill on that same edge is not yet visible to this read
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			vtags_o[w] <= vtag_mem[w][rndx_i];
		end
	end

	// Physical tags are needed in the snoop cycle itself
	// so this side of the store is read without a register
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			ptags_o[w] = ptag_mem[w][ptag_ndx_i];
		end
	end

endmodule

/* source/icache_hit_way.sv */
// Tag compare and hit way encoder for one bank with the registered hit
module icache_hit_way #(
	parameter int WAYS = 4
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             lookup_v_i,
	input  icache_pkg::line_tag_t            tag_i,
	input  icache_pkg::line_tag_t [WAYS-1:0] vtags_i,
	input  logic [WAYS-1:0]                  valid_i,
	output logic                             hit_o,
	output logic [$clog2(WAYS)-1:0]          way_o
);

	import icache_pkg::*;

	localparam int WW = $clog2(WAYS);

	// Lookup strobe and tag held for the compare stage
	logic      lookup_v_q;
	line_tag_t tag_q;
	logic [WAYS-1:0] match;

	// A compare result only counts in the cycle after a lookup strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lookup_v_q <= 1'b0;
		end else begin
			lookup_v_q <= lookup_v_i;
		end
	end

	always_ff @(posedge clk) begin
		tag_q <= tag_i;
	end

	// Compare against every way that holds a valid line
	// The encoded way addresses the data RAM in the same cycle
	always_comb begin
		way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid_i[w] && (vtags_i[w] == tag_q);
			if (match[w]) begin
				way_o = WW'(w);
			end
		end
	end

	// Hit lines up with the registered data RAM output
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= lookup_v_q && (|match);
		end
	end

	// The fill side picks the way, so a line must never sit in two ways of a set
	assert property (@(posedge clk) disable iff (rst) lookup_v_q |-> $onehot0(match));

endmodule

/* source/icache_bank.sv */
// Cache bank with valid bits, fill, line and snoop invalidation, tags, hit logic and data RAM
module icache_bank #(
	parameter int              WAYS = 4,
	parameter icache_pkg::cid_t CID  = 4'd2,
	parameter bit              BANK = 1'b0
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     lookup_v_i,
	input  icache_pkg::line_addr_t   lookup_adr_i,
	input  logic                     fill_v_i,
	input  icache_pkg::fill_line_t   fill_line_i,
	input  logic [$clog2(WAYS)-1:0]  fill_way_i,
	input  logic                     inv_v_i,
	input  logic                     inv_all_i,
	input  icache_pkg::line_addr_t   inv_adr_i,
	input  logic                     snoop_v_i,
	input  icache_pkg::addr_t        snoop_adr_i,
	input  icache_pkg::cid_t         snoop_cid_i,
	output logic                     hit_o,
	output icache_pkg::line_data_t   data_o
);

	import icache_pkg::*;

	localparam int WW = $clog2(WAYS);

	// Set and tag fields of the lookup, fill, invalidate and snoop addresses
	set_index_t lookup_ndx;
	set_index_t fill_ndx;
	set_index_t inv_ndx;
	set_index_t snoop_ndx;
	logic       snoop_hit;
	logic       inv_line_hit;

	logic [WAYS-1:0] valid_q [LINES];
	logic [WAYS-1:0] valid_rd_q;
	set_index_t      lookup_ndx_q;
	line_tag_t [WAYS-1:0] vtags;
	line_tag_t [WAYS-1:0] ptags;
	logic [WW-1:0]   hit_way;

	// Delayed data write so a lookup on the fill edge still reads the old line
	logic            ram_wr_q;
	logic [WW+$bits(set_index_t)-1:0] ram_wadr_q;
	line_data_t      ram_wdata_q;

	assign lookup_ndx = lookup_adr_i[8:5];
	assign fill_ndx   = fill_line_i.vadr[8:5];
	assign inv_ndx    = inv_adr_i[8:5];
	assign snoop_ndx  = snoop_adr_i[8:5];

	// A line invalidate only touches the bank that holds the line
	assign inv_line_hit = inv_adr_i[4] == BANK;

	// Snoops from this cache itself are ignored
	assign snoop_hit = snoop_v_i && (snoop_cid_i != CID) && (snoop_adr_i[4] == BANK);

// ==========================================================================
// Valid bits
// ==========================================================================

	// A fill wins over an invalidate on the same edge
	// and a matching snoop clears afterwards, so it can undo that fill
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < LINES; s++) begin
				valid_q[s] <= '0;
			end
			valid_rd_q <= '0;
		end else begin
			if (fill_v_i) begin
				valid_q[fill_ndx][fill_way_i] <= 1'b1;
			end else if (inv_v_i && inv_all_i) begin
				for (int s = 0; s < LINES; s++) begin
					valid_q[s] <= '0;
				end
			end else if (inv_v_i && inv_line_hit) begin
				valid_q[inv_ndx] <= '0;
			end
			for (int w = 0; w < WAYS; w++) begin
				if (snoop_hit && (ptags[w] == snoop_adr_i[31:9])) begin
					valid_q[snoop_ndx][w] <= 1'b0;
				end
			end
			// Valid bits of the looked up set as they were before this edge
			if (lookup_v_i) begin
				valid_rd_q <= valid_q[lookup_ndx];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ram_wr_q <= 1'b0;
		end else begin
			ram_wr_q <= fill_v_i;
		end
	end

	// Set index follows the lookup into the data stage
	always_ff @(posedge clk) begin
		lookup_ndx_q <= lookup_ndx;
		ram_wadr_q   <= {fill_way_i, fill_ndx};
		ram_wdata_q  <= fill_line_i.data;
	end

// ==========================================================================
// Tag store, hit and data
// ==========================================================================

	icache_tag_store #(.WAYS(WAYS)) u_tags (
		.clk        (clk),
		.wr_i       (fill_v_i),
		.way_i      (fill_way_i),
		.ndx_i      (fill_ndx),
		.vtag_i     (fill_line_i.vadr[31:9]),
		.ptag_i     (fill_line_i.ptag),
		.rndx_i     (lookup_ndx),
		.vtags_o    (vtags),
		.ptag_ndx_i (snoop_ndx),
		.ptags_o    (ptags)
	);

	icache_hit_way #(.WAYS(WAYS)) u_hit (
		.clk        (clk),
		.rst        (rst),
		.lookup_v_i (lookup_v_i),
		.tag_i      (lookup_adr_i[31:9]),
		.vtags_i    (vtags),
		.valid_i    (valid_rd_q),
		.hit_o      (hit_o),
		.way_o      (hit_way)
	);

	icache_line_ram #(.WAYS(WAYS)) u_ram (
		.clk     (clk),
		.wr_i    (ram_wr_q),
		.wadr_i  (ram_wadr_q),
		.radr_i  ({hit_way, lookup_ndx_q}),
		.wdata_i (ram_wdata_q),
		.rdata_o (data_o)
	);

	// The top level steers each fill by the bank bit of its line address
	assert property (@(posedge clk) disable iff (rst)
		fill_v_i |-> (int'(fill_way_i) < WAYS) && (fill_line_i.vadr[4] == BANK));

endmodule

/* source/icache_top.sv */
// Instruction cache top with even and odd bank lookup and low and high line assembly
module icache_top #(
	parameter int               WAYS = 4,
	parameter icache_pkg::cid_t CID  = 4'd2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fetch_v_i,
	input  icache_pkg::addr_t        fetch_adr_i,
	input  logic                     fill_v_i,
	input  icache_pkg::fill_line_t   fill_line_i,
	input  logic [$clog2(WAYS)-1:0]  fill_way_i,
	input  logic                     inv_v_i,
	input  logic                     inv_all_i,
	input  icache_pkg::line_addr_t   inv_adr_i,
	input  logic                     snoop_v_i,
	input  icache_pkg::addr_t        snoop_adr_i,
	input  icache_pkg::cid_t         snoop_cid_i,
	output logic                     fetch_v_o,
	output icache_pkg::addr_t        fetch_adr_o,
	output logic                     hit_o,
	output icache_pkg::fetch_line_t  line_lo_o,
	output icache_pkg::fetch_line_t  line_hi_o
);

	import icache_pkg::*;

	line_addr_t fetch_line;
	line_addr_t even_sum;
	line_addr_t even_adr;
	line_addr_t odd_adr;
	line_addr_t cur_line;
	line_addr_t next_line;

	logic       fetch_v_q1;
	logic       fetch_v_q2;
	addr_t      fetch_adr_q1;
	addr_t      fetch_adr_q2;

	logic       even_hit;
	logic       odd_hit;
	line_data_t even_data;
	line_data_t odd_data;

// ==========================================================================
// Bank lookup addresses
// ==========================================================================

	assign fetch_line = fetch_adr_i[31:4];

	// The odd line is always the fetch line or the one after it
	assign odd_adr = {fetch_line[31:5], 1'b1};

	// For an odd fetch line the even line needed is the next one up
	// which can carry into the tag
	assign even_sum = fetch_line + line_addr_t'(fetch_line[4]);
	assign even_adr = {even_sum[31:5], 1'b0};

	// Strobe and address follow the banks through their two stages
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetch_v_q1 <= 1'b0;
			fetch_v_q2 <= 1'b0;
		end else begin
			fetch_v_q1 <= fetch_v_i;
			fetch_v_q2 <= fetch_v_q1;
		end
	end

	always_ff @(posedge clk) begin
		fetch_adr_q1 <= fetch_adr_i;
		fetch_adr_q2 <= fetch_adr_q1;
	end

// ==========================================================================
// Banks
// ==========================================================================

	icache_bank #(.WAYS(WAYS), .CID(CID), .BANK(1'b0)) u_even (
		.clk (clk), .rst (rst),
		.lookup_v_i (fetch_v_i), .lookup_adr_i (even_adr),
		.fill_v_i (fill_v_i && !fill_line_i.vadr[4]),
		.fill_line_i (fill_line_i), .fill_way_i (fill_way_i),
		.inv_v_i (inv_v_i), .inv_all_i (inv_all_i), .inv_adr_i (inv_adr_i),
		.snoop_v_i (snoop_v_i), .snoop_adr_i (snoop_adr_i), .snoop_cid_i (snoop_cid_i),
		.hit_o (even_hit), .data_o (even_data)
	);

	icache_bank #(.WAYS(WAYS), .CID(CID), .BANK(1'b1)) u_odd (
		.clk (clk), .rst (rst),
		.lookup_v_i (fetch_v_i), .lookup_adr_i (odd_adr),
		.fill_v_i (fill_v_i && fill_line_i.vadr[4]),
		.fill_line_i (fill_line_i), .fill_way_i (fill_way_i),
		.inv_v_i (inv_v_i), .inv_all_i (inv_all_i), .inv_adr_i (inv_adr_i),
		.snoop_v_i (snoop_v_i), .snoop_adr_i (snoop_adr_i), .snoop_cid_i (snoop_cid_i),
		.hit_o (odd_hit), .data_o (odd_data)
	);

// ==========================================================================
// Output lines
// ==========================================================================

	assign fetch_v_o   = fetch_v_q2;
	assign fetch_adr_o = fetch_adr_q2;
	assign cur_line    = fetch_adr_q2[31:4];
	assign next_line   = cur_line + 1'b1;

	// Both lines must be present for the fetch to count as a hit
	assign hit_o = even_hit && odd_hit;

	// The bank bit of the delayed fetch says which bank holds the low line
	always_comb begin
		line_lo_o.vadr = cur_line;
		line_hi_o.vadr = next_line;
		if (fetch_adr_q2[4]) begin
			line_lo_o.v    = odd_hit;
			line_lo_o.data = odd_data;
			line_hi_o.v    = even_hit;
			line_hi_o.data = even_data;
		end else begin
			line_lo_o.v    = even_hit;
			line_lo_o.data = even_data;
			line_hi_o.v    = odd_hit;
			line_hi_o.data = odd_data;
		end
	end

endmodule

/* dv/tb_clock.sv */
// Free running testbench clock
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk_o
);

	// Starts low so the first rising edge comes half a period in
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

/* dv/icache_tb.sv */
// Instruction cache testbench with LFSR stimulus, a reference line model and output checks
module icache_tb;

	import icache_pkg::*;

	localparam int        WAYS       = 4;
	localparam cid_t      CID        = 4'd2;
	localparam int        WW         = $clog2(WAYS);
	localparam int        MIX_CYCLES = 1500;
	// The 64 line pool starts halfway into the first tag, so it spans three tags
	localparam line_tag_t TAG_BASE   = 23'h1a2b3;
	// Physical tags are the virtual tags with this pattern flipped in
	localparam line_tag_t PTAG_XOR   = 23'h5a5a5;

	// One fetch as the model expects it back from the DUT
	typedef struct packed {
		int          cyc;
		addr_t       adr;
		logic        hit;
		fetch_line_t lo;
		fetch_line_t hi;
	} fetch_exp_t;

	logic           clk;
	logic           rst;
	logic           fetch_v;
	addr_t          fetch_adr;
	logic           fill_v;
	fill_line_t     fill_line;
	logic [WW-1:0]  fill_way;
	logic           inv_v;
	logic           inv_all;
	line_addr_t     inv_adr;
	logic           snoop_v;
	addr_t          snoop_adr;
	cid_t           snoop_cid;
	logic           out_v;
	addr_t          out_adr;
	logic           hit;
	fetch_line_t    line_lo;
	fetch_line_t    line_hi;

	// Model state per bank, way and set
	logic       m_valid [2][WAYS][LINES];
	line_tag_t  m_vtag  [2][WAYS][LINES];
	line_tag_t  m_ptag  [2][WAYS][LINES];
	line_data_t m_data  [2][WAYS][LINES];

	fetch_exp_t  exp_q [$];
	int          cyc;
	int          checks;
	int          errors;
	logic [31:0] lfsr;

	tb_clock #(.PERIOD(8)) clk_gen (.clk_o(clk));

	icache_top #(.WAYS(WAYS), .CID(CID)) dut_i (
		.clk (clk), .rst (rst),
		.fetch_v_i (fetch_v), .fetch_adr_i (fetch_adr),
		.fill_v_i (fill_v), .fill_line_i (fill_line), .fill_way_i (fill_way),
		.inv_v_i (inv_v), .inv_all_i (inv_all), .inv_adr_i (inv_adr),
		.snoop_v_i (snoop_v), .snoop_adr_i (snoop_adr), .snoop_cid_i (snoop_cid),
		.fetch_v_o (out_v), .fetch_adr_o (out_adr), .hit_o (hit),
		.line_lo_o (line_lo), .line_hi_o (line_hi)
	);

// ==========================================================================
// Random numbers and the reference model
// ==========================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1 that shifts once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic line_addr_t pool_line();
		return {TAG_BASE, 5'd16} + line_addr_t'(take_bits(6));
	endfunction

	// A line lives in the bank of its bit 4 and the set of bits 8 to 5
	function automatic fetch_line_t model_line(input line_addr_t x);
		fetch_line_t r;
		r.v    = 1'b0;
		r.vadr = x;
		r.data = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[x[4]][w][x[8:5]] && (m_vtag[x[4]][w][x[8:5]] == x[31:9])) begin
				r.v    = 1'b1;
				r.data = m_data[x[4]][w][x[8:5]];
			end
		end
		return r;
	endfunction

	// Returns the way that already holds the line or -1 when it is not cached
	function automatic int find_way(input line_addr_t x);
		int way;
		way = -1;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[x[4]][w][x[8:5]] && (m_vtag[x[4]][w][x[8:5]] == x[31:9])) begin
				way = w;
			end
		end
		return way;
	endfunction

	// Applies the inputs driven this cycle as the next rising edge will
	task automatic update_model();
		logic [WAYS-1:0] snoop_clr;
		line_addr_t      fa;
		snoop_clr = '0;
		fa        = fill_line.vadr;
		// Snoops compare against the physical tags from before a same-cycle fill
		if (snoop_v && (snoop_cid != CID)) begin
			for (int w = 0; w < WAYS; w++) begin
				snoop_clr[w] = m_ptag[snoop_adr[4]][w][snoop_adr[8:5]] == snoop_adr[31:9];
			end
		end
		for (int b = 0; b < 2; b++) begin
			if (fill_v && (fa[4] == b)) begin
				m_valid[b][fill_way][fa[8:5]] = 1'b1;
				m_vtag[b][fill_way][fa[8:5]]  = fa[31:9];
				m_ptag[b][fill_way][fa[8:5]]  = fill_line.ptag;
				m_data[b][fill_way][fa[8:5]]  = fill_line.data;
			end else if (inv_v && inv_all) begin
				for (int w = 0; w < WAYS; w++) begin
					for (int s = 0; s < LINES; s++) begin
						m_valid[b][w][s] = 1'b0;
					end
				end
			end else if (inv_v && (inv_adr[4] == b)) begin
				for (int w = 0; w < WAYS; w++) begin
					m_valid[b][w][inv_adr[8:5]] = 1'b0;
				end
			end
		end
		// The snoop clear lands after the fill and can undo it
		for (int w = 0; w < WAYS; w++) begin
			if (snoop_clr[w]) begin
				m_valid[snoop_adr[4]][w][snoop_adr[8:5]] = 1'b0;
			end
		end
	endtask

// ==========================================================================
// Checks
// ==========================================================================

	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	// A fetch driven in cycle c shows up at the falling edge of cycle c+2
	task automatic check_outputs();
		fetch_exp_t e;
		logic       due;
		due = (exp_q.size() > 0) && (exp_q[0].cyc == cyc - 2);
		check_value("fetch_v_o", 128'(due), 128'(out_v));
		if (due) begin
			e = exp_q.pop_front();
			if (out_v) begin
				check_value("fetch_adr_o", 128'(e.adr), 128'(out_adr));
				check_value("hit_o", 128'(e.hit), 128'(hit));
				check_value("line_lo_o.v", 128'(e.lo.v), 128'(line_lo.v));
				check_value("line_lo_o.vadr", 128'(e.lo.vadr), 128'(line_lo.vadr));
				check_value("line_hi_o.v", 128'(e.hi.v), 128'(line_hi.v));
				check_value("line_hi_o.vadr", 128'(e.hi.vadr), 128'(line_hi.vadr));
				// Data only means something on a line that hit
				if (e.lo.v) begin
					check_value("line_lo_o.data", e.lo.data, line_lo.data);
				end
				if (e.hi.v) begin
					check_value("line_hi_o.data", e.hi.data, line_hi.data);
				end
			end
		end else begin
			check_value("hit_o", 128'(1'b0), 128'(hit));
		end
	endtask

// ==========================================================================
// Stimulus
// ==========================================================================

	// Each step checks the outputs of one cycle, drives new requests and then advances the model
	task automatic step(input logic do_fetch, input logic do_fill, input logic do_inv,
			input logic do_all, input logic do_snoop);
		fetch_exp_t e;
		line_addr_t fl;
		line_addr_t sl;
		int         way;
		@(negedge clk);
		cyc++;
		check_outputs();
		fetch_v = do_fetch;
		fill_v  = do_fill;
		inv_v   = do_inv;
		inv_all = do_all;
		snoop_v = do_snoop;
		if (do_fetch) begin
			fl        = pool_line();
			fetch_adr = {fl, 4'(take_bits(4))};
			e.cyc     = cyc;
			e.adr     = fetch_adr;
			e.lo      = model_line(fl);
			e.hi      = model_line(fl + 1'b1);
			e.hit     = e.lo.v && e.hi.v;
			exp_q.push_back(e);
		end
		if (do_fill) begin
			fill_line.vadr = pool_line();
			fill_line.ptag = fill_line.vadr[31:9] ^ PTAG_XOR;
			for (int q = 0; q < 4; q++) begin
				fill_line.data[q*32 +: 32] = take_bits(32);
			end
			// A line already cached is refilled in place so it never sits in two ways
			way = find_way(fill_line.vadr);
			if (way < 0) begin
				way = int'(take_bits(WW));
			end
			fill_way = WW'(way);
		end
		if (do_inv) begin
			inv_adr = pool_line();
		end
		if (do_snoop) begin
			sl        = pool_line();
			snoop_adr = {sl[31:9] ^ PTAG_XOR, sl[8:4], 4'(take_bits(4))};
			snoop_cid = (take_bits(1) != 0) ? CID : cid_t'(take_bits(4));
		end
		update_model();
	endtask

	initial begin
		logic f;
		logic fi;
		logic iv;
		logic al;
		logic sn;
		int   timeout;
		lfsr      = 32'hf051;
		cyc       = 0;
		checks    = 0;
		errors    = 0;
		rst       = 1'b1;
		fetch_v   = 1'b0;
		fetch_adr = '0;
		fill_v    = 1'b0;
		fill_line = '0;
		fill_way  = '0;
		inv_v     = 1'b0;
		inv_all   = 1'b0;
		inv_adr   = '0;
		snoop_v   = 1'b0;
		snoop_adr = '0;
		snoop_cid = '0;
		for (int b = 0; b < 2; b++) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < LINES; s++) begin
					m_valid[b][w][s] = 1'b0;
					m_vtag[b][w][s]  = '0;
					m_ptag[b][w][s]  = '0;
					m_data[b][w][s]  = '0;
				end
			end
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Fetches into the empty cache must all miss
		for (int i = 0; i < 24; i++) begin
			step(take_bits(1) != 0, 1'b0, 1'b0, 1'b0, 1'b0);
		end

		// Mixed fetches, fills, invalidates and snoops
		for (int i = 0; i < MIX_CYCLES; i++) begin
			f  = take_bits(1) != 0;
			fi = take_bits(1) != 0;
			iv = take_bits(4) == 0;
			al = take_bits(3) == 0;
			sn = take_bits(3) == 0;
			step(f, fi, iv, al, sn);
		end

		// Invalidate everything, after which every fetch misses
		step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
		for (int i = 0; i < 40; i++) begin
			step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		end

		timeout = 0;
		while ((exp_q.size() > 0) && (timeout < 16)) begin
			step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			timeout++;
		end
		if (exp_q.size() > 0) begin
			errors++;
			$display("Timed out waiting for %0d fetch results", exp_q.size());
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* tb.f */
source/icache_pkg.sv
source/icache_line_ram.sv
source/icache_tag_store.sv
source/icache_hit_way.sv
source/icache_bank.sv
source/icache_top.sv
dv/tb_clock.sv
dv/icache_tb.sv

/* Makefile */
TOP := icache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
